// File: rtl/ttc_pkg.sv
/*
 * Shared types and constants for the triple-match timer/counter
 * Register map, mode and interrupt encodings, bus and config structs
 */
`default_nettype none

package ttc_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned CNT_W     = 16;  // Counter and register data
  localparam int unsigned NUM_INTR  = 5;   // Interrupt sources
  localparam int unsigned NUM_MATCH = 3;   // Match comparators

  // Register addresses
  typedef enum logic [3:0] {
    REG_CTRL      = 4'h0,
    REG_INTERVAL  = 4'h1,
    REG_MATCH1    = 4'h2,
    REG_MATCH2    = 4'h3,
    REG_MATCH3    = 4'h4,
    REG_COUNT     = 4'h5,  // Read only
    REG_INTR_EN   = 4'h6,
    REG_INTR_STAT = 4'h7   // Read clears
  } ttc_reg_e;

  typedef enum logic {
    MODE_INTERVAL = 1'b0,  // Wrap at interval value
    MODE_OVERFLOW = 1'b1   // Wrap at all ones
  } ttc_mode_e;

  // Bit positions in event, enable and status vectors
  typedef enum int unsigned {
    INTR_INTERVAL = 0,
    INTR_MATCH1   = 1,
    INTR_MATCH2   = 2,
    INTR_MATCH3   = 3,
    INTR_OVERFLOW = 4
  } ttc_intr_e;

  // REG_CTRL field positions, restart is a strobe only
  localparam int unsigned CTRL_EN_BIT      = 0;
  localparam int unsigned CTRL_MODE_BIT    = 1;
  localparam int unsigned CTRL_RESTART_BIT = 2;

  // ----------------------------------------
  // Structs
  // ----------------------------------------
  typedef struct packed {
    logic             write;  // 1 = write, 0 = read
    ttc_reg_e         addr;
    logic [CNT_W-1:0] wdata;
  } ttc_bus_req_t;

  typedef struct packed {
    logic                             enable;
    ttc_mode_e                        mode;
    logic [CNT_W-1:0]                 interval;
    logic [NUM_MATCH-1:0][CNT_W-1:0]  match;  // match[0] is match 1
  } ttc_cnt_cfg_t;

endpackage

`default_nettype wire

// File: rtl/ttc_reg_if.sv
/*
 * Register slave behind a four-phase req/ack handshake
 * Holds counter setup and interrupt enables; status read strobes a clear
 */
`default_nettype none

module ttc_reg_if
  import ttc_pkg::*;
#(
  parameter int unsigned N_SRC = NUM_INTR
) (
  input  wire                 pclk18,
  input  wire                 n_p_reset18,
  input  wire                 req,
  input  wire ttc_bus_req_t   bus_req,      // Stable while req high
  output logic                ack,
  output logic [CNT_W-1:0]    rdata,
  output ttc_cnt_cfg_t        cnt_cfg,
  output logic                restart,      // One-cycle strobe
  output logic [N_SRC-1:0]    intr_en,
  output logic                clear_intr,   // One-cycle strobe
  input  wire  [CNT_W-1:0]    count,
  input  wire  [N_SRC-1:0]    intr_stat
);

  typedef enum logic {S_IDLE, S_ACK} state_e;

  state_e           state_q;
  logic             take;     // Access accepted on this edge
  logic [CNT_W-1:0] rd_mux;

  assign take = (state_q == S_IDLE) && req;
  assign ack  = (state_q == S_ACK);

  // ----------------------------------------
  // Handshake FSM
  // ----------------------------------------
  always_ff @(posedge pclk18 or negedge n_p_reset18)
  begin
    if (!n_p_reset18)
      state_q <= S_IDLE;
    else
    begin
      case (state_q)
        S_IDLE: if (req) state_q <= S_ACK;     // Access done on this edge
        S_ACK:  if (!req) state_q <= S_IDLE;   // Master released
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Write decode and strobes
  // ----------------------------------------
  always_ff @(posedge pclk18 or negedge n_p_reset18)
  begin
    if (!n_p_reset18)
    begin
      cnt_cfg    <= '0;    // Disabled, interval mode
      intr_en    <= '0;
      restart    <= 1'b0;
      clear_intr <= 1'b0;
    end
    else
    begin
      restart    <= 1'b0;  // Strobes default low
      clear_intr <= 1'b0;
      if (take && bus_req.write)
      begin
        case (bus_req.addr)
          REG_CTRL:
          begin
            cnt_cfg.enable <= bus_req.wdata[CTRL_EN_BIT];
            cnt_cfg.mode   <= ttc_mode_e'(bus_req.wdata[CTRL_MODE_BIT]);
            restart        <= bus_req.wdata[CTRL_RESTART_BIT];  // Not stored
          end
          REG_INTERVAL: cnt_cfg.interval <= bus_req.wdata;
          REG_MATCH1:   cnt_cfg.match[0] <= bus_req.wdata;
          REG_MATCH2:   cnt_cfg.match[1] <= bus_req.wdata;
          REG_MATCH3:   cnt_cfg.match[2] <= bus_req.wdata;
          REG_INTR_EN:  intr_en <= bus_req.wdata[N_SRC-1:0];
          default: ;   // Count and status ignore writes
        endcase
      end
      // Reading status clears it one edge later
      if (take && !bus_req.write && (bus_req.addr == REG_INTR_STAT))
        clear_intr <= 1'b1;
    end
  end

  // Read mux
  always_comb
  begin
    rd_mux = '0;
    case (bus_req.addr)
      REG_CTRL:      rd_mux[1:0] = {cnt_cfg.mode, cnt_cfg.enable};
      REG_INTERVAL:  rd_mux = cnt_cfg.interval;
      REG_MATCH1:    rd_mux = cnt_cfg.match[0];
      REG_MATCH2:    rd_mux = cnt_cfg.match[1];
      REG_MATCH3:    rd_mux = cnt_cfg.match[2];
      REG_COUNT:     rd_mux = count;
      REG_INTR_EN:   rd_mux[N_SRC-1:0] = intr_en;
      REG_INTR_STAT: rd_mux[N_SRC-1:0] = intr_stat;
      default: ;
    endcase
  end

  always_ff @(posedge pclk18)
  begin
    if (take && !bus_req.write)
      rdata <= rd_mux;   // Valid while ack high
  end

  // Slave only answers a request that was present on the edge before
  a_ack_needs_req: assert property (@(posedge pclk18) disable iff (!n_p_reset18)
    $rose(ack) |-> $past(req));

endmodule

`default_nettype wire

// File: rtl/ttc_counter.sv
/*
 * 16-bit counter, interval or overflow mode, with three match compares
 * Drives level events for interval wrap, matches and overflow
 */
`default_nettype none

module ttc_counter
  import ttc_pkg::*;
#(
  parameter int unsigned N_SRC = NUM_INTR
) (
  input  wire                pclk18,
  input  wire                n_p_reset18,
  input  wire ttc_cnt_cfg_t  cnt_cfg,
  input  wire                restart,    // Zero count on next edge
  output logic [CNT_W-1:0]   count,
  output logic [N_SRC-1:0]   events
);

  logic [CNT_W-1:0]     wrap_val;    // Last value before wrap
  logic                 at_wrap;
  logic [NUM_MATCH-1:0] match_hit;
  logic                 in_range_q;  // Restarted since interval/mode change
  logic [CNT_W-1:0]     interval_q;  // Interval seen at last restart

  assign wrap_val = (cnt_cfg.mode == MODE_INTERVAL) ? cnt_cfg.interval : '1;
  assign at_wrap  = (count == wrap_val);

  // ----------------------------------------
  // Count register
  // ----------------------------------------
  always_ff @(posedge pclk18 or negedge n_p_reset18)
  begin
    if (!n_p_reset18)
      count <= '0;
    else if (restart)
      count <= '0;                 // Restart wins over enable
    else if (cnt_cfg.enable)
    begin
      if (at_wrap)
        count <= '0;
      else
        count <= count + 1'b1;     // Wraps naturally past all ones
    end
  end

  // Match comparators
  for (genvar i = 0; i < NUM_MATCH; i++)
  begin : g_match
    assign match_hit[i] = cnt_cfg.enable && (count == cnt_cfg.match[i]);
  end

  // Level events, high for the cycle the condition holds
  always_comb
  begin
    events = '0;
    events[INTR_INTERVAL] = cnt_cfg.enable && (cnt_cfg.mode == MODE_INTERVAL) && at_wrap;
    events[int'(INTR_MATCH1) +: NUM_MATCH] = match_hit;
    events[INTR_OVERFLOW] = cnt_cfg.enable && (cnt_cfg.mode == MODE_OVERFLOW) && at_wrap;
  end

  // ----------------------------------------
  // Range tracking for the interval check
  // ----------------------------------------
  always_ff @(posedge pclk18 or negedge n_p_reset18)
  begin
    if (!n_p_reset18)
    begin
      in_range_q <= 1'b0;
      interval_q <= '0;
    end
    else if (restart)
    begin
      in_range_q <= (cnt_cfg.mode == MODE_INTERVAL);
      interval_q <= cnt_cfg.interval;
    end
    else if ((cnt_cfg.interval != interval_q) || (cnt_cfg.mode != MODE_INTERVAL))
      in_range_q <= 1'b0;   // Needs a new restart
  end

  // Once restarted under the current interval, count stays in range
  a_count_in_range: assert property (@(posedge pclk18) disable iff (!n_p_reset18)
    (in_range_q && (cnt_cfg.mode == MODE_INTERVAL) && (cnt_cfg.interval == interval_q))
      |-> (count <= cnt_cfg.interval));

endmodule

`default_nettype wire

// File: rtl/ttc_interrupt.sv
/*
 * Interrupt capture: registers each event, catches its rising edge,
 * keeps enabled edges in status until read, drives the irq line
 */
`default_nettype none

module ttc_interrupt
  import ttc_pkg::*;
#(
  parameter int unsigned N_SRC = NUM_INTR
) (
  input  wire              pclk18,
  input  wire              n_p_reset18,
  input  wire [N_SRC-1:0]  events,      // Level events from counter
  input  wire [N_SRC-1:0]  intr_en,
  input  wire              clear_intr,  // Strobe from status read
  output logic [N_SRC-1:0] intr_stat,
  output logic             irq
);

  logic [N_SRC-1:0] sync_q;     // Event level, one cycle late
  logic [N_SRC-1:0] edge_q;     // Rising edges, one cycle wide
  logic [N_SRC-1:0] new_bits;   // Enabled edges to record
  logic             set_q;      // Edge captured last cycle

  assign new_bits = edge_q & intr_en;

  // ----------------------------------------
  // Edge capture and status
  // ----------------------------------------
  always_ff @(posedge pclk18 or negedge n_p_reset18)
  begin
    if (!n_p_reset18)
    begin
      sync_q    <= '0;
      edge_q    <= '0;
      set_q     <= 1'b0;
      intr_stat <= '0;
    end
    else
    begin
      sync_q <= events;
      edge_q <= events & ~sync_q;   // Low last cycle, high now
      set_q  <= |edge_q;

      // Guard: skip the clear if an edge just landed, so it is not lost
      if (clear_intr && !set_q)
        intr_stat <= new_bits;
      else
        intr_stat <= intr_stat | new_bits;
    end
  end

  assign irq = |intr_stat;   // Level, held until status read

  // An enabled edge always reaches the line, clear strobe or not
  a_edge_to_irq: assert property (@(posedge pclk18) disable iff (!n_p_reset18)
    (new_bits != '0) |=> irq);

endmodule

`default_nettype wire

// File: rtl/ttc_top.sv
/*
 * Timer/counter subsystem top: register slave, counter, interrupt block
 * Bus master drives req/bus_req; irq is a level output
 */
`default_nettype none

module ttc_top
  import ttc_pkg::*;
#(
  parameter int unsigned N_SRC = NUM_INTR   // Interrupt source count
) (
  input  wire                pclk18,
  input  wire                n_p_reset18,
  input  wire                req,
  input  wire ttc_bus_req_t  bus_req,
  output logic               ack,
  output logic [CNT_W-1:0]   rdata,
  output logic               irq
);

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------
  ttc_cnt_cfg_t     cnt_cfg;
  logic             restart;      // Reg slave to counter
  logic             clear_intr;   // Reg slave to interrupt block
  logic [N_SRC-1:0] intr_en;
  logic [N_SRC-1:0] intr_stat;
  logic [N_SRC-1:0] events;
  logic [CNT_W-1:0] count;

  ttc_reg_if #(.N_SRC(N_SRC)) u_reg_if (
    .pclk18      (pclk18),
    .n_p_reset18 (n_p_reset18),
    .req         (req),
    .bus_req     (bus_req),
    .ack         (ack),
    .rdata       (rdata),
    .cnt_cfg     (cnt_cfg),
    .restart     (restart),
    .intr_en     (intr_en),
    .clear_intr  (clear_intr),
    .count       (count),
    .intr_stat   (intr_stat)
  );

  ttc_counter #(.N_SRC(N_SRC)) u_counter (
    .pclk18      (pclk18),
    .n_p_reset18 (n_p_reset18),
    .cnt_cfg     (cnt_cfg),
    .restart     (restart),
    .count       (count),
    .events      (events)
  );

  ttc_interrupt #(.N_SRC(N_SRC)) u_interrupt (
    .pclk18      (pclk18),
    .n_p_reset18 (n_p_reset18),
    .events      (events),
    .intr_en     (intr_en),
    .clear_intr  (clear_intr),
    .intr_stat   (intr_stat),
    .irq         (irq)
  );

endmodule

`default_nettype wire

// File: sim/ttc_tb.sv
/*
 * Testbench for the timer/counter subsystem: four-phase bus master,
 * random counter runs checked against a status model, watchdog
 */
`default_nettype none

module ttc_tb
  import ttc_pkg::*;
();

  localparam int SHORT_MAX = 150;           // Longest short run
  localparam int LONG_MAX  = 65536 + 100;   // Overflow run
  localparam int LIMIT     = 16 + 200 + 8 * (SHORT_MAX + 200) + (LONG_MAX + 200) + 1000;

  logic                pclk18 = 1'b0;
  logic                n_p_reset18;
  logic                req;
  ttc_bus_req_t        bus_req;
  logic                ack;
  logic [CNT_W-1:0]    rdata;
  logic                irq;

  // Model of the registers written
  ttc_mode_e           m_mode;
  logic [CNT_W-1:0]    m_interval;
  logic [CNT_W-1:0]    m_match [3];
  logic [NUM_INTR-1:0] m_en;

  int errors    = 0;
  int tests_run = 0;
  int tests_bad = 0;

  ttc_top u_dut (
    .pclk18      (pclk18),
    .n_p_reset18 (n_p_reset18),
    .req         (req),
    .bus_req     (bus_req),
    .ack         (ack),
    .rdata       (rdata),
    .irq         (irq)
  );

  always #4 pclk18 = ~pclk18;   // Period 8

  // ----------------------------------------
  // Bus master, called on a falling edge
  // ----------------------------------------
  task automatic bus_write(input ttc_reg_e addr, input logic [CNT_W-1:0] data);
    bus_req.write = 1'b1;
    bus_req.addr  = addr;
    bus_req.wdata = data;
    req = 1'b1;
    while (!ack)
      @(negedge pclk18);
    req = 1'b0;   // Release after ack
    while (ack)
      @(negedge pclk18);
  endtask

  task automatic bus_read(input ttc_reg_e addr, output logic [CNT_W-1:0] data);
    bus_req.write = 1'b0;
    bus_req.addr  = addr;
    bus_req.wdata = '0;
    req = 1'b1;
    while (!ack)
      @(negedge pclk18);
    data = rdata;   // Valid while ack high
    req  = 1'b0;
    while (ack)
      @(negedge pclk18);
  endtask

  task automatic check_equal(input string name, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] got);
    assert (got == exp)
    else
    begin
      $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic bit clear_of(input int n);   // N at least 4 from every compare
    bit ok;
    ok = 1'b1;
    if ((m_mode == MODE_INTERVAL) && ((n - int'(m_interval)) inside {[-3:3]}))
      ok = 1'b0;
    for (int i = 0; i < 3; i++)
      if ((n - int'(m_match[i])) inside {[-3:3]})
        ok = 1'b0;
    return ok;
  endfunction

  function automatic logic [NUM_INTR-1:0] expected_status(input int n);
    logic [NUM_INTR-1:0] s;
    int                  wrap;
    s    = '0;
    wrap = (m_mode == MODE_INTERVAL) ? int'(m_interval) : 65535;
    for (int i = 0; i < 3; i++)
      if ((int'(m_match[i]) <= wrap) && (int'(m_match[i]) < n))
        s[int'(INTR_MATCH1) + i] = 1'b1;   // Count values 0..N-1 seen
    if (n > wrap)
      s[(m_mode == MODE_INTERVAL) ? INTR_INTERVAL : INTR_OVERFLOW] = 1'b1;
    return s & m_en;
  endfunction

  task automatic readback_test();
    ttc_reg_e         regs [5];
    logic [CNT_W-1:0] vals [5];
    logic [CNT_W-1:0] got;
    int               err_before;
    err_before = errors;
    regs = '{REG_INTERVAL, REG_MATCH1, REG_MATCH2, REG_MATCH3, REG_INTR_EN};
    for (int i = 0; i < 5; i++)
    begin
      vals[i] = 16'($urandom_range(65535, 0));
      if (i == 4)
        vals[i] = {11'b0, vals[i][NUM_INTR-1:0]};   // Enable is 5 bits wide
      bus_write(regs[i], vals[i]);
    end
    for (int i = 0; i < 5; i++)
    begin
      bus_read(regs[i], got);
      check_equal(regs[i].name(), vals[i], got);
    end
    bus_write(REG_CTRL, 16'h0001);   // Let the counter move off zero
    repeat (8)
      @(negedge pclk18);
    bus_write(REG_CTRL, 16'h0004);   // Stop and restart in one write
    bus_read(REG_COUNT, got);
    check_equal("count", '0, got);
    bus_read(REG_INTR_STAT, got);    // Drop status left by the short run
    report_test("register readback", err_before);
  endtask

  // One counter run, then status, read-clear and stop checks
  task automatic run_case(input string name, input ttc_mode_e mode,
                          input logic [NUM_INTR-1:0] en, input bit long_run);
    int                  n;
    int                  wrap;
    int                  err_before;
    bit                  irq_seen;
    logic [CNT_W-1:0]    got;
    logic [CNT_W-1:0]    c1;
    logic [CNT_W-1:0]    c2;
    logic [NUM_INTR-1:0] exp;
    err_before = errors;
    irq_seen   = 1'b0;
    m_mode     = mode;
    m_en       = en;
    m_interval = (mode == MODE_INTERVAL) ? 16'($urandom_range(79, 16))
                                         : 16'($urandom_range(7, 1));   // Ignored here
    for (int i = 0; i < 3; i++)
      m_match[i] = 16'($urandom_range(99, 4));
    do
      n = long_run ? 65536 + int'($urandom_range(100, 8)) : int'($urandom_range(SHORT_MAX, 8));
    while (!clear_of(n));

    bus_write(REG_INTERVAL, m_interval);
    bus_write(REG_MATCH1, m_match[0]);
    bus_write(REG_MATCH2, m_match[1]);
    bus_write(REG_MATCH3, m_match[2]);
    bus_write(REG_INTR_EN, {11'b0, m_en});
    bus_write(REG_CTRL, {13'b0, 1'b1, m_mode, 1'b0});   // Restart while off

    bus_write(REG_CTRL, {14'b0, m_mode, 1'b1});   // Start
    repeat (n - 2)   // Two cycles spent in the handshake
    begin
      @(negedge pclk18);
      if (irq)
        irq_seen = 1'b1;
    end
    bus_write(REG_CTRL, {14'b0, m_mode, 1'b0});   // Stop
    repeat (4)
      @(negedge pclk18);   // Let edge capture settle

    exp = expected_status(n);
    if (en == '0)
    begin
      assert (!irq_seen)
      else
      begin
        $display("irq went high during a run with every interrupt disabled");
        errors++;
      end
    end
    check_equal("irq", 16'(exp != '0), 16'(irq));
    bus_read(REG_INTR_STAT, got);
    check_equal("intr_stat", 16'(exp), got);
    bus_read(REG_INTR_STAT, got);   // Cleared by first read
    check_equal("intr_stat", '0, got);
    check_equal("irq", '0, 16'(irq));

    bus_read(REG_COUNT, c1);
    repeat ($urandom_range(20, 3))
      @(negedge pclk18);
    bus_read(REG_COUNT, c2);
    check_equal("count", c1, c2);   // Frozen
    wrap = (mode == MODE_INTERVAL) ? int'(m_interval) : 65535;
    check_equal("count", 16'(n % (wrap + 1)), c1);   // N counts from zero, within wrap
    report_test(name, err_before);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    void'($urandom(51));
    req         = 1'b0;
    bus_req     = '0;
    n_p_reset18 = 1'b0;
    repeat (16)
      @(posedge pclk18);
    @(negedge pclk18);
    n_p_reset18 = 1'b1;
    @(negedge pclk18);

    readback_test();
    for (int i = 0; i < 3; i++)
      run_case("interval, all enabled", MODE_INTERVAL, '1, 1'b0);
    for (int i = 0; i < 3; i++)
      run_case("interval, random mask", MODE_INTERVAL, 5'($urandom_range(31, 1)), 1'b0);
    run_case("interval, mask zero", MODE_INTERVAL, '0, 1'b0);
    run_case("overflow, short run", MODE_OVERFLOW, '1, 1'b0);
    run_case("overflow, past wrap", MODE_OVERFLOW, '1, 1'b1);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_bad, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Watchdog sized from the worst-case run lengths
  initial
  begin
    repeat (LIMIT)
      @(posedge pclk18);
    $display("Timeout: tests did not finish within %0d cycles", LIMIT);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
rtl/ttc_pkg.sv
rtl/ttc_reg_if.sv
rtl/ttc_counter.sv
rtl/ttc_interrupt.sv
rtl/ttc_top.sv
sim/ttc_tb.sv

// File: run.sh
#!/bin/sh
# Build the timer/counter testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module ttc_tb -o ttc_sim
./obj_dir/ttc_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "Simulation did not complete"
  exit 1
fi
echo "Simulation passed"
